// File: hdl/fir_pkg.sv
// **************************************************
// fir_pkg
// widths, coefficient table and shared types for the
// 22-tap symmetric FIR filter
// **************************************************

`default_nettype none

package fir_pkg;

	// **************************************************
	// sizes
	// **************************************************

	// input and output sample width
	localparam int SAMPLE_W = 18;

	// filter length and unique coefficient count
	localparam int NUM_TAPS = 22;
	localparam int NUM_UNIQ = 11;

	// one bit of growth for a mirror-pair sum
	localparam int FOLD_W = 19;

	// products and sums kept at full precision
	localparam int ACC_W = 40;

	// normalization of the total sum
	localparam int SCALE_SHIFT = 17;

	// enabled clocks from input capture to output
	localparam int PIPE_DEPTH = 4;

	// **************************************************
	// types
	// **************************************************

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// coefficients share the sample width
	typedef logic signed [SAMPLE_W-1:0] coeff_t;

	typedef logic signed [ACC_W-1:0] acc_t;

	// one pre-added mirror pair
	typedef logic signed [FOLD_W-1:0] fold_t;

	// pair k is tap k plus tap NUM_TAPS-1-k
	typedef struct packed {
		fold_t [NUM_UNIQ-1:0] pair;
	} folded_t;

	// partial sum tagged with its valid strobe
	typedef struct packed {
		acc_t sum;
		logic valid;
	} partial_t;

	// unique half of the symmetric impulse response
	localparam coeff_t COEFFS [NUM_UNIQ] = '{
		88, 0, -97, -197, -294, -380, -447, -490, -504, -481, -420
	};

endpackage

`default_nettype wire

// File: hdl/fir_tap_line.sv
// **************************************************
// fir_tap_line
// sample delay line of the FIR filter with registered
// mirror-pair pre-adders and a matching valid delay
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module fir_tap_line #(
	parameter int NUM_TAPS = fir_pkg::NUM_TAPS
) (
	input  wire              i_clk,
	input  wire              i_reset,
	input  wire              i_clk_ena,
	input  fir_pkg::sample_t i_in,
	input  wire              i_valid,
	output fir_pkg::folded_t o_folded,
	output logic             o_valid
);

	import fir_pkg::*;

	// tap 0 holds the newest sample
	sample_t taps [NUM_TAPS];

	// valid strobe aligned with the taps
	logic valid_tap;

	// **************************************************
	// delay line
	// **************************************************

	// shifts on every enabled clock whether or not the sample is valid
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				taps[i] <= '0;
			end
			valid_tap <= 1'b0;
		end else if (i_clk_ena) begin
			taps[0] <= i_in;
			for (int i = 1; i < NUM_TAPS; i++) begin
				taps[i] <= taps[i-1];
			end
			valid_tap <= i_valid;
		end
	end

	// **************************************************
	// mirror-pair pre-adders
	// **************************************************

	// sign-extend both taps before adding so the pair cannot wrap
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_folded <= '0;
			o_valid <= 1'b0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				o_folded.pair[k] <= fold_t'(taps[k]) + fold_t'(taps[NUM_TAPS-1-k]);
			end
			o_valid <= valid_tap;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fir_product_sum.sv
// **************************************************
// fir_product_sum
// multiplies one group of folded pairs by their
// coefficients and registers the full-precision sum
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module fir_product_sum #(
	parameter int GROUP_BASE = 0,
	parameter int GROUP_LEN = 6
) (
	input  wire               i_clk,
	input  wire               i_reset,
	input  wire               i_clk_ena,
	input  fir_pkg::folded_t  i_folded,
	input  wire               i_valid,
	output fir_pkg::partial_t o_partial
);

	import fir_pkg::*;

	// one product per pair in this group
	acc_t prod [GROUP_LEN];

	// combinational sum of the group
	acc_t sum;

	// **************************************************
	// multipliers
	// **************************************************

	// both operands widened to the accumulator width first,
	// so the product is exact
	for (genvar k = 0; k < GROUP_LEN; k++) begin : g_prod
		assign prod[k] = acc_t'(i_folded.pair[GROUP_BASE + k])
			* acc_t'(COEFFS[GROUP_BASE + k]);
	end

	// **************************************************
	// adder tree and partial sum register
	// **************************************************

	always_comb begin
		sum = '0;
		for (int k = 0; k < GROUP_LEN; k++) begin
			sum = sum + prod[k];
		end
	end

	// valid travels with the sum
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_partial <= '0;
		end else if (i_clk_ena) begin
			o_partial.sum <= sum;
			o_partial.valid <= i_valid;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fir_output_stage.sv
// **************************************************
// fir_output_stage
// adds the two partial sums, scales to the sample width
// and registers the filter output with its valid
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module fir_output_stage (
	input  wire               i_clk,
	input  wire               i_reset,
	input  wire               i_clk_ena,
	input  fir_pkg::partial_t i_low,
	input  fir_pkg::partial_t i_high,
	output fir_pkg::sample_t  o_out,
	output logic              o_valid
);

	import fir_pkg::*;

	// full-precision total of both halves
	acc_t total;

	// total after normalization
	acc_t scaled;

	// **************************************************
	// combine and scale
	// **************************************************

	assign total = i_low.sum + i_high.sum;

	// arithmetic shift keeps the sign of the total
	assign scaled = total >>> SCALE_SHIFT;

	// **************************************************
	// output register
	// **************************************************

	// low sample bits only; anything above them is dropped.
	// both halves carry the same valid, the low one is taken
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_out <= '0;
			o_valid <= 1'b0;
		end else if (i_clk_ena) begin
			o_out <= scaled[SAMPLE_W-1:0];
			o_valid <= i_low.valid;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fir_top.sv
// **************************************************
// fir_top
// 22-tap symmetric FIR filter, four enabled clocks
// from input sample to output sample
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module fir_top #(
	parameter int NUM_TAPS = fir_pkg::NUM_TAPS
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              i_clk_ena,
	input  wire              i_valid,
	input  fir_pkg::sample_t i_in,
	output logic             o_valid,
	output fir_pkg::sample_t o_out
);

	import fir_pkg::*;

	// tap line to product sums
	folded_t folded;
	logic    folded_valid;

	// product sums to output stage
	partial_t part_low;
	partial_t part_high;

	fir_tap_line #(
		.NUM_TAPS (NUM_TAPS)
	) u_tap_line (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.i_valid   (i_valid),
		.o_folded  (folded),
		.o_valid   (folded_valid)
	);

	// pairs 0 to 5
	fir_product_sum #(
		.GROUP_BASE (0),
		.GROUP_LEN  (6)
	) u_sum_low (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_clk_ena (i_clk_ena),
		.i_folded  (folded),
		.i_valid   (folded_valid),
		.o_partial (part_low)
	);

	// pairs 6 to 10
	fir_product_sum #(
		.GROUP_BASE (6),
		.GROUP_LEN  (5)
	) u_sum_high (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_clk_ena (i_clk_ena),
		.i_folded  (folded),
		.i_valid   (folded_valid),
		.o_partial (part_high)
	);

	fir_output_stage u_output_stage (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_clk_ena (i_clk_ena),
		.i_low     (part_low),
		.i_high    (part_high),
		.o_out     (o_out),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

// File: test/fir_checker.sv
// **************************************************
// fir_checker
// assertions on reset, enable hold and valid latency
// of the FIR top level, bound into fir_top
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module fir_checker (
	input wire              clk,
	input wire              reset,
	input wire              i_clk_ena,
	input wire              i_valid,
	input wire              o_valid,
	input fir_pkg::sample_t o_out
);

	// enabled edge outside reset
	wire run = !reset && i_clk_ena;

	// failed assertions so far, read by the testbench
	int fail_count = 0;

	// outputs cleared one clock into reset and right after it
	a_reset_clears: assert property (@(posedge clk)
		reset |=> !o_valid && o_out == '0)
		else begin
			$error("o_out or o_valid not cleared by reset");
			fail_count++;
		end

	// a disabled clock changes nothing
	a_hold_when_disabled: assert property (@(posedge clk) disable iff (reset)
		!$past(i_clk_ena) |-> $stable(o_out) && $stable(o_valid))
		else begin
			$error("output changed on a clock with i_clk_ena low");
			fail_count++;
		end

	// four enabled edges from i_valid to o_valid
	a_valid_latency: assert property (@(posedge clk) disable iff (reset)
		$past(run, 1) && $past(run, 2) && $past(run, 3) && $past(run, 4)
		|-> o_valid == $past(i_valid, 4))
		else begin
			$error("o_valid does not follow i_valid four enabled clocks later");
			fail_count++;
		end

endmodule

bind fir_top fir_checker u_checker (
	.clk       (clk),
	.reset     (reset),
	.i_clk_ena (i_clk_ena),
	.i_valid   (i_valid),
	.o_valid   (o_valid),
	.o_out     (o_out)
);

`default_nettype wire

// File: test/fir_tb.sv
// **************************************************
// fir_tb
// testbench for the 22-tap FIR filter with LFSR stimulus,
// a reference model, output comparison and reporting
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module fir_tb;

	import fir_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 2;

	// test lengths in clocks
	localparam int LEN_IMPULSE = NUM_TAPS;
	localparam int LEN_CONST = 60;
	localparam int LEN_RANDOM = 200;
	localparam int LEN_RESET = 40;
	localparam int DRAIN = PIPE_DEPTH + 2;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + LEN_IMPULSE + 2 * LEN_CONST
		+ 3 * LEN_RANDOM + 2 * LEN_RESET + RESET_CYCLES + 1 + 6 * (DRAIN + 2) + 100;

	localparam sample_t MAX_SAMPLE = sample_t'(131071);
	localparam sample_t MIN_SAMPLE = sample_t'(-131072);

	logic    clk = 1'b0;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	// reference state
	sample_t hist [NUM_TAPS];
	sample_t exp_q [$];
	logic    ena_prev = 1'b0;

	// counters
	int   checked = 0;
	int   pushed = 0;
	int   cmp_errors = 0;
	int   seq_errors = 0;
	int   cycles = 0;
	int   base_checked;
	int   base_errors;
	logic [31:0] lfsr;

	fir_top #(
		.NUM_TAPS (NUM_TAPS)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	always #CLK_HALF clk = ~clk;

	// **************************************************
	// helpers
	// **************************************************

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// sum over pairs of coeff times (x[n-k] + x[n-21+k]), then scaled
	function automatic sample_t ref_output(input sample_t h [NUM_TAPS]);
		longint acc;
		acc = 0;
		for (int k = 0; k < NUM_UNIQ; k++) begin
			acc += longint'(COEFFS[k]) * (longint'(h[k]) + longint'(h[NUM_TAPS-1-k]));
		end
		ref_output = sample_t'(acc >>> SCALE_SHIFT);
	endfunction

	// settled output for a constant input level
	function automatic sample_t steady_value(input sample_t level);
		longint coeff_sum;
		coeff_sum = 0;
		for (int k = 0; k < NUM_UNIQ; k++) begin
			coeff_sum += longint'(COEFFS[k]);
		end
		steady_value = sample_t'((coeff_sum * longint'(level) * longint'(2)) >>> SCALE_SHIFT);
	endfunction

	// sequence, comparison and assertion failures together
	function automatic int error_count();
		error_count = seq_errors + cmp_errors + UUT.u_checker.fail_count;
	endfunction

	task automatic check(input string name, input int got, input int expected, inout int errs);
		if (got !== expected) begin
			$display("Fail at %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
			errs++;
		end
	endtask

	// one LFSR step per bit
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic random_sample(output sample_t s);
		logic [31:0] bits;
		take_bits(SAMPLE_W, bits);
		s = sample_t'(bits[SAMPLE_W-1:0]);
	endtask

	task automatic drive(input logic ena, input logic vld, input sample_t din);
		@(posedge clk);
		i_clk_ena <= ena;
		i_valid <= vld;
		i_in <= din;
	endtask

	task automatic start_test;
		base_checked = checked;
		base_errors = error_count();
	endtask

	// flush the pipeline, then report the test
	task automatic finish_test(input string name);
		repeat (DRAIN) drive(1'b1, 1'b0, '0);
		@(negedge clk);
		if (exp_q.size() != 0) begin
			$display("%s: %0d expected outputs never appeared on o_valid", name, exp_q.size());
			seq_errors++;
		end
		$display("test %s: %0d outputs checked, %0d errors", name,
			checked - base_checked, error_count() - base_errors);
	endtask

	// **************************************************
	// reference model and comparison
	// **************************************************

	always @(posedge clk) begin : model_and_compare
		sample_t expected;
		// the output seen now came from the previous enabled edge
		if (ena_prev && o_valid) begin
			if (exp_q.size() == 0) begin
				$display("Error at %0d ns: o_valid is high with no valid input waiting", $time);
				cmp_errors++;
			end else begin
				expected = exp_q.pop_front();
				check("o_out", int'(o_out), int'(expected), cmp_errors);
				checked++;
			end
		end
		if (reset) begin
			for (int k = 0; k < NUM_TAPS; k++) begin
				hist[k] = '0;
			end
			exp_q.delete();
			ena_prev = 1'b0;
		end else begin
			ena_prev = i_clk_ena;
			if (i_clk_ena) begin
				for (int k = NUM_TAPS - 1; k > 0; k--) begin
					hist[k] = hist[k-1];
				end
				hist[0] = i_in;
				if (i_valid) begin
					exp_q.push_back(ref_output(hist));
					pushed++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	// **************************************************
	// test sequence
	// **************************************************

	initial begin : main_sequence
		sample_t     din;
		logic [31:0] bits;
		int          total;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		lfsr = 32'ha356;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		start_test;
		drive(1'b1, 1'b1, MAX_SAMPLE);
		repeat (LEN_IMPULSE - 1) drive(1'b1, 1'b1, '0);
		finish_test("1 impulse response");

		start_test;
		repeat (LEN_CONST) drive(1'b1, 1'b1, MIN_SAMPLE);
		@(negedge clk);
		check("o_out", int'(o_out), int'(steady_value(MIN_SAMPLE)), seq_errors);
		repeat (LEN_CONST) drive(1'b1, 1'b1, MAX_SAMPLE);
		@(negedge clk);
		check("o_out", int'(o_out), int'(steady_value(MAX_SAMPLE)), seq_errors);
		finish_test("2 full-scale constant");

		start_test;
		repeat (LEN_RANDOM) begin
			random_sample(din);
			drive(1'b1, 1'b1, din);
		end
		finish_test("3 random stream");

		// enable high on about three clocks in four
		start_test;
		repeat (LEN_RANDOM) begin
			take_bits(2, bits);
			random_sample(din);
			drive(bits[1:0] != 2'b00, 1'b1, din);
		end
		finish_test("4 enable gaps");

		start_test;
		repeat (LEN_RANDOM) begin
			take_bits(1, bits);
			random_sample(din);
			drive(1'b1, bits[0], din);
		end
		finish_test("5 valid gaps");

		start_test;
		repeat (LEN_RESET) begin
			random_sample(din);
			drive(1'b1, 1'b1, din);
		end
		@(posedge clk);
		reset <= 1'b1;
		i_valid <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check("o_valid", int'(o_valid), 0, seq_errors);
		repeat (LEN_RESET) begin
			random_sample(din);
			drive(1'b1, 1'b1, din);
		end
		finish_test("6 reset mid-stream");

		total = error_count();
		$display("%0d outputs checked, %0d valid inputs sent, %0d errors", checked, pushed, total);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hdl/fir_pkg.sv
hdl/fir_tap_line.sv
hdl/fir_product_sum.sv
hdl/fir_output_stage.sv
hdl/fir_top.sv
test/fir_checker.sv
test/fir_tb.sv

// File: Makefile
# Verilator build and run for the FIR filter testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fir_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Result: FAILED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crash or a failed assertion also counts as failure
run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
